/* hdl/cpu_pkg.sv */
//**************************************************
// Shared ISA definitions: opcodes, field widths,
// bus frame constants and the instruction word union
//**************************************************
package cpu_pkg;

  // Instruction field widths
  localparam int unsigned opcode_w = 4;
  localparam int unsigned reg_w    = 3;
  localparam int unsigned imm_w    = 22;
  localparam int unsigned unused_w = 32 - opcode_w - 3 * reg_w;

  // Register form opcodes
  localparam logic [opcode_w-1:0] op_add  = 4'h0;  // rd = rs1 + rs2
  localparam logic [opcode_w-1:0] op_sub  = 4'h1;  // rd = rs1 - rs2
  localparam logic [opcode_w-1:0] op_xor  = 4'h2;  // rd = rs1 ^ rs2

  // Immediate form opcodes, imm is sign extended
  localparam logic [opcode_w-1:0] op_addi = 4'h3;  // rd = rs1 + imm
  localparam logic [opcode_w-1:0] op_ld   = 4'h4;  // rd = mem[rs1 + imm]
  localparam logic [opcode_w-1:0] op_st   = 4'h5;  // mem[rs1 + imm] = rd
  localparam logic [opcode_w-1:0] op_beqz = 4'h6;  // If rs1 == 0 then pc = pc + imm
  localparam logic [opcode_w-1:0] op_halt = 4'h7;  // Other codes also halt

  // Pin frame layout
  localparam logic [3:0] phase_last = 4'd8;   // Last phase of a frame
  localparam logic [3:0] frame_len  = 4'd9;   // Phases per frame
  localparam int unsigned cmd_valid_bit = 7;  // Set in every command byte
  localparam logic [3:0] word_bytes = 4'd4;   // Bytes per bus word

  localparam int unsigned reg_count = 8;      // r0 reads as zero

  // One instruction word, decoded either as register or immediate form.
  // The opcode, rd and rs1 fields line up in both views.
  typedef union packed {
    struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rd;
      logic [reg_w-1:0]    rs1;
      logic [reg_w-1:0]    rs2;
      logic [unused_w-1:0] unused;
    } r;
    struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rd;
      logic [reg_w-1:0]    rs1;
      logic [imm_w-1:0]    imm;
    } i;
  } cpu_instr_u;

endpackage

/* hdl/cpu_fetch.sv */
//**************************************************
// Instruction fetch: pc, one-word buffer, fetch requests
//**************************************************
`timescale 1ns/1ps

module cpu_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                fetch_ack,
  input  logic [31:0]         bus_rdata,
  input  logic                instr_take,
  input  logic                redirect,
  input  logic [31:0]         redirect_pc,
  output logic                fetch_req,
  output logic [31:0]         fetch_addr,
  output cpu_pkg::cpu_instr_u instr,
  output logic [31:0]         instr_pc,
  output logic                instr_valid
);
  import cpu_pkg::*;

  logic [31:0] pc;       // Address of the next word to fetch
  logic        discard;  // Fetch in flight belongs to a flushed path
  logic        issue;
  logic        fill;

  // New request when the buffer is free now or frees this cycle
  assign issue = run && !fetch_req && !redirect && (!instr_valid || instr_take);
  assign fill  = fetch_ack && !discard && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= 32'h0;
      fetch_req   <= 1'b0;
      instr_valid <= 1'b0;
      discard     <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;  // Taken branch reloads the pc
      end else if (issue) begin
        pc <= pc + 32'(word_bytes);
      end

      if (issue) begin
        fetch_req <= 1'b1;
      end else if (fetch_ack) begin
        fetch_req <= 1'b0;
      end

      if (redirect) begin
        instr_valid <= 1'b0;  // Flush
      end else if (fill) begin
        instr_valid <= 1'b1;
      end else if (instr_take) begin
        instr_valid <= 1'b0;
      end

      if (fetch_ack) begin
        discard <= 1'b0;
      end else if (redirect && fetch_req) begin
        discard <= 1'b1;  // Let the frame finish, drop its word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      fetch_addr <= pc;
    end
    if (fill) begin
      instr    <= bus_rdata;
      instr_pc <= fetch_addr;  // Word address becomes the branch base
    end
  end

  a_fetch_addr_stable : assert property (
    @(posedge clk) disable iff (reset)
    fetch_req && !fetch_ack |=> $stable(fetch_addr)
  );

endmodule

/* hdl/cpu_execute.sv */
//**************************************************
// Execute unit: register file, ALU, branch,
// load/store requests and halt
//**************************************************
`timescale 1ns/1ps

module cpu_execute (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::cpu_instr_u instr,
  input  logic [31:0]         instr_pc,
  input  logic                instr_valid,
  input  logic                data_ack,
  input  logic [31:0]         bus_rdata,
  output logic                instr_take,
  output logic                redirect,
  output logic [31:0]         redirect_pc,
  output logic                data_req,
  output logic                data_we,
  output logic [31:0]         data_addr,
  output logic [31:0]         data_wdata,
  output logic                halted
);
  import cpu_pkg::*;

  logic [31:0] regs [reg_count];

  logic [opcode_w-1:0] opcode;
  logic [reg_w-1:0]    rd_idx;
  logic [reg_w-1:0]    rs1_idx;
  logic [reg_w-1:0]    rs2_idx;
  logic [31:0]         rd_val;
  logic [31:0]         rs1_val;
  logic [31:0]         rs2_val;
  logic [31:0]         imm_ext;
  logic [31:0]         alu_result;

  logic is_alu;    // Any op that writes back from the ALU
  logic is_mem;
  logic is_beqz;
  logic is_halt;
  logic can_issue;

  logic [reg_w-1:0] load_rd;  // Destination of the outstanding load
  logic             wr_en;
  logic [reg_w-1:0] wr_idx;
  logic [31:0]      wr_data;

  assign opcode  = instr.r.opcode;
  assign rd_idx  = instr.r.rd;
  assign rs1_idx = instr.r.rs1;
  assign rs2_idx = instr.r.rs2;
  assign imm_ext = {{(32 - imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

  // r0 is hardwired to zero
  assign rd_val  = (rd_idx == '0) ? 32'h0 : regs[rd_idx];
  assign rs1_val = (rs1_idx == '0) ? 32'h0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0) ? 32'h0 : regs[rs2_idx];

  always_comb begin
    is_alu     = 1'b0;
    is_mem     = 1'b0;
    is_beqz    = 1'b0;
    is_halt    = 1'b0;
    alu_result = 32'h0;
    case (opcode)
      op_add: begin
        is_alu     = 1'b1;
        alu_result = rs1_val + rs2_val;
      end
      op_sub: begin
        is_alu     = 1'b1;
        alu_result = rs1_val - rs2_val;
      end
      op_xor: begin
        is_alu     = 1'b1;
        alu_result = rs1_val ^ rs2_val;
      end
      op_addi: begin
        is_alu     = 1'b1;
        alu_result = rs1_val + imm_ext;
      end
      op_ld, op_st: is_mem  = 1'b1;
      op_beqz:      is_beqz = 1'b1;
      default:      is_halt = 1'b1;  // op_halt and unknown codes
    endcase
  end

  // One instruction at a time, nothing while a load or store waits
  assign can_issue = instr_valid && !data_req && !halted;

  // Halt stays in the buffer, which keeps fetch quiet afterwards
  assign instr_take  = can_issue && !is_halt;
  assign redirect    = can_issue && is_beqz && (rs1_val == 32'h0);
  assign redirect_pc = instr_pc + imm_ext;

  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = rd_idx;
    wr_data = alu_result;
    if (data_req && data_ack && !data_we) begin
      wr_en   = 1'b1;  // Load return
      wr_idx  = load_rd;
      wr_data = bus_rdata;
    end else if (can_issue && is_alu) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_req <= 1'b0;
      halted   <= 1'b0;
    end else begin
      if (can_issue && is_mem) begin
        data_req <= 1'b1;
      end else if (data_ack) begin
        data_req <= 1'b0;
      end
      if (can_issue && is_halt) begin
        halted <= 1'b1;  // Sticky until reset
      end
    end
  end

  // Access fields held steady while data_req is up
  always_ff @(posedge clk) begin
    if (can_issue && is_mem) begin
      data_we    <= (opcode == op_st);
      data_addr  <= rs1_val + imm_ext;
      data_wdata <= rd_val;
      load_rd    <= rd_idx;
    end
  end

  a_no_req_after_halt : assert property (
    @(posedge clk) disable iff (reset)
    halted |=> !$rose(data_req)
  );

endmodule

/* hdl/bus_arbiter.sv */
//**************************************************
// Fixed-priority bus arbiter, data over fetch
//**************************************************
`timescale 1ns/1ps

module bus_arbiter (
  input  logic        clk,
  input  logic        reset,
  input  logic        fetch_req,
  input  logic [31:0] fetch_addr,
  input  logic        data_req,
  input  logic        data_we,
  input  logic [31:0] data_addr,
  input  logic [31:0] data_wdata,
  input  logic        bus_ack,
  output logic        fetch_ack,
  output logic        data_ack,
  output logic        bus_req,
  output logic        bus_we,
  output logic [31:0] bus_addr,
  output logic [31:0] bus_wdata
);

  logic granted;     // Bus owned from grant to ack
  logic owner_data;  // 1 = execute unit, 0 = fetch unit

  always_ff @(posedge clk) begin
    if (reset) begin
      granted    <= 1'b0;
      owner_data <= 1'b0;
    end else if (!granted) begin
      if (data_req || fetch_req) begin
        granted    <= 1'b1;
        owner_data <= data_req;  // Data wins a tie
      end
    end else if (bus_ack) begin
      granted <= 1'b0;
    end
  end

  // Owner is frozen while granted, so fields cannot switch mid frame
  assign bus_req   = granted;
  assign bus_we    = owner_data && data_we;
  assign bus_addr  = owner_data ? data_addr : fetch_addr;
  assign bus_wdata = data_wdata;  // Fetch never writes

  assign fetch_ack = bus_ack && granted && !owner_data;
  assign data_ack  = bus_ack && granted && owner_data;

  a_one_ack : assert property (
    @(posedge clk) disable iff (reset)
    !(fetch_ack && data_ack)
  );

  // Owner keeps its request up until its frame is acknowledged
  a_owner_holds : assert property (
    @(posedge clk) disable iff (reset)
    granted && !bus_ack |-> (owner_data ? data_req : fetch_req)
  );

endmodule

/* hdl/pin_sequencer.sv */
//**************************************************
// Nine-phase pin frame engine: command, address and
// write bytes out, read bytes in
//**************************************************
`timescale 1ns/1ps

module pin_sequencer (
  input  logic        clk,
  input  logic        reset,
  input  logic        bus_req,
  input  logic        bus_we,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_wdata,
  input  logic [7:0]  uio_in,
  output logic        bus_ack,
  output logic [31:0] bus_rdata,
  output logic [7:0]  uo_out,
  output logic [7:0]  uio_out,
  output logic [7:0]  uio_oe
);
  import cpu_pkg::*;

  logic        active;       // Frame in progress
  logic [3:0]  phase;
  logic        frame_we;
  logic [31:0] frame_addr;
  logic [31:0] frame_wdata;

  logic        start;
  logic        addr_phase;   // Phases 1 to 4
  logic        read_phase;   // Phases 5 to 8
  logic [3:0]  phase_m1;
  logic [1:0]  byte_idx;
  logic [7:0]  cmd_byte;

  // Ack cycle still shows the old request, so skip it
  assign start = bus_req && !active && !bus_ack;

  assign addr_phase = (phase != 4'd0) && (phase <= word_bytes);
  assign read_phase = (phase > word_bytes);
  assign phase_m1   = phase - 4'd1;
  assign byte_idx   = phase_m1[1:0];  // Low byte first

  always_comb begin
    cmd_byte                = 8'h00;
    cmd_byte[cmd_valid_bit] = 1'b1;
    cmd_byte[0]             = frame_we;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active  <= 1'b0;
      phase   <= 4'd0;
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= 1'b0;
      if (start) begin
        active <= 1'b1;
        phase  <= 4'd0;
      end else if (active) begin
        if (phase == phase_last) begin
          active  <= 1'b0;
          bus_ack <= 1'b1;  // One cycle after phase 8
        end else begin
          phase <= phase + 4'd1;
        end
      end
    end
  end

  // Access captured at the start of the frame
  always_ff @(posedge clk) begin
    if (start) begin
      frame_we    <= bus_we;
      frame_addr  <= bus_addr;
      frame_wdata <= bus_wdata;
    end
    if (active && read_phase && !frame_we) begin
      bus_rdata <= {uio_in, bus_rdata[31:8]};  // Fill from the top
    end
  end

  always_comb begin
    uo_out  = 8'h00;
    uio_out = 8'h00;
    uio_oe  = 8'h00;
    if (active) begin
      if (phase == 4'd0) begin
        uo_out = cmd_byte;
      end else if (addr_phase) begin
        uo_out = frame_addr[8 * byte_idx +: 8];
        if (frame_we) begin
          uio_out = frame_wdata[8 * byte_idx +: 8];
          uio_oe  = 8'hff;
        end
      end
    end
  end

  a_oe_write_only : assert property (
    @(posedge clk) disable iff (reset)
    (uio_oe != 8'h00) |-> active && frame_we && addr_phase
  );

  // Full frame length from phase 0 to ack
  a_frame_len : assert property (
    @(posedge clk) disable iff (reset)
    $rose(bus_ack) |-> $past(active, frame_len) && $past(phase, frame_len) == 4'd0
  );

endmodule

/* hdl/cpu_handler_top.sv */
//**************************************************
// CPU handler top: fetch, execute, arbiter, pins
//**************************************************
`timescale 1ns/1ps

module cpu_handler_top (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] ui_in,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);
  import cpu_pkg::*;

  cpu_instr_u  instr;
  logic [31:0] instr_pc;
  logic        instr_valid;
  logic        instr_take;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        halted;

  logic        fetch_req;
  logic [31:0] fetch_addr;
  logic        fetch_ack;
  logic        data_req;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_ack;

  logic        bus_req;
  logic        bus_we;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_ack;
  logic [31:0] bus_rdata;  // Shared by both requesters

  cpu_fetch i_cpu_fetch (
    .clk, .reset,
    .run         (ui_in[0]),
    .fetch_ack, .bus_rdata, .instr_take, .redirect, .redirect_pc,
    .fetch_req, .fetch_addr, .instr, .instr_pc, .instr_valid
  );

  cpu_execute i_cpu_execute (
    .clk, .reset, .instr, .instr_pc, .instr_valid, .data_ack, .bus_rdata,
    .instr_take, .redirect, .redirect_pc,
    .data_req, .data_we, .data_addr, .data_wdata, .halted
  );

  bus_arbiter i_bus_arbiter (
    .clk, .reset,
    .fetch_req, .fetch_addr, .data_req, .data_we, .data_addr, .data_wdata,
    .bus_ack, .fetch_ack, .data_ack,
    .bus_req, .bus_we, .bus_addr, .bus_wdata
  );

  pin_sequencer i_pin_sequencer (
    .clk, .reset, .bus_req, .bus_we, .bus_addr, .bus_wdata, .uio_in,
    .bus_ack, .bus_rdata, .uo_out, .uio_out, .uio_oe
  );

  // Once halted, neither unit has anything left on the bus
  a_bus_quiet_when_halted : assert property (
    @(posedge clk) disable iff (reset)
    halted |-> !bus_req
  );

endmodule

/* bench/cpu_handler_tb.sv */
//**************************************************
// Testbench: clock, reset, pin-level memory model,
// frame monitor, run pauses and result checks
//**************************************************
`timescale 1ns/1ps

module cpu_handler_tb;
  import cpu_pkg::*;

  localparam int prog_words  = 16;                  // Program at address 0
  localparam int data_words  = 2;                   // Initial data at data_base
  localparam int store_base  = prog_words + data_words + 1;
  localparam int stim_len    = store_base + 8;      // Up to 4 store records
  localparam logic [31:0] data_base = 32'h100;
  localparam int idle_cycles = 20;
  localparam int pause_long  = 2 * frame_len + 9;   // Longest run pause
  localparam int pause_max   = 80;
  localparam int pause_limit = 2 * frame_len;       // Pending fetch frames start before this

  logic       clk = 1'b0;
  logic       reset;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [31:0] stim [0:stim_len-1];
  logic [31:0] mem [0:127];                         // Word index is addr[8:2]
  logic [31:0] loaded [$];                          // Words handed out by load frames
  int          errors [1:6];
  int          checks;
  integer      seed;

  logic        in_frame;
  int          ph;
  logic        fr_we;
  logic        fr_paused;                           // Frame began deep in a pause
  logic [31:0] fr_addr;
  logic [31:0] fr_wdata;
  logic [31:0] rd_word;
  logic [7:0]  uio_next;                            // Read byte for the next phase

  int          fetch_count;
  int          stores_done;
  int          store_count;
  int          run_low;
  int          pause_left;
  int          paused_total;
  int          cycles;
  int          cycle_limit;
  logic [31:0] last_fetch;
  logic [31:0] branch_target;
  logic        branch_pending;
  logic        halt_fetched;
  logic        done;
  logic        run_enable;
  logic        paused;

  cpu_handler_top i_cpu_handler_top (
    .clk, .reset, .ui_in, .uio_in, .uo_out, .uio_out, .uio_oe
  );

  always #2 clk = ~clk;

  task automatic check(input bit ok, input int id, input string msg);
    checks++;
    assert (ok) else begin
      $display("Fail at %0t ns: %s", $time, msg);
      errors[id]++;
    end
  endtask

  function automatic logic [31:0] imm_of(input cpu_instr_u w);
    return {{(32 - imm_w){w.i.imm[imm_w-1]}}, w.i.imm};
  endfunction

  // Next fetch is pc + 4, or the target of a beqz fetched just before
  task automatic follow_fetch();
    cpu_instr_u w;
    logic       order_ok;
    w = rd_word;
    if (fetch_count == 0) begin
      order_ok = (fr_addr == 32'h0);
    end else begin
      order_ok = (fr_addr == last_fetch + 32'(word_bytes)) ||
                 (branch_pending && fr_addr == branch_target);
    end
    check(order_ok, 2, $sformatf("fetch from %h after %h", fr_addr, last_fetch));
    check(!fr_paused, 6, $sformatf("fetch frame for %h began while run was low", fr_addr));
    branch_pending = (w.i.opcode == op_beqz);
    branch_target  = fr_addr + imm_of(w);
    if (w.i.opcode >= op_halt) begin
      halt_fetched = 1'b1;  // Unknown codes halt too
    end
    last_fetch = fr_addr;
    fetch_count++;
  endtask

  task automatic match_store();
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    check(stores_done < store_count, 6, "more stores than expected");
    if (stores_done < store_count) begin
      exp_addr = stim[store_base + 2 * stores_done];
      exp_data = stim[store_base + 2 * stores_done + 1];
      check(fr_addr == exp_addr && fr_wdata == exp_data, 3,
            $sformatf("store %h to %h, expected %h to %h",
                      fr_wdata, fr_addr, exp_data, exp_addr));
    end
    // First store holds the first loaded word plus the imm of program word 2
    if (stores_done == 0) begin
      check(loaded.size() > 0, 4, "first store came before any load");
      if (loaded.size() > 0) begin
        check(fr_wdata == loaded[0] + imm_of(stim[2]), 4,
              $sformatf("store %h, loaded word was %h", fr_wdata, loaded[0]));
      end
    end
    mem[fr_addr[8:2]] = fr_wdata;
    stores_done++;
  endtask

  task automatic close_frame();
    if (fr_we) begin
      match_store();
    end else if (fr_addr < data_base) begin
      follow_fetch();
    end else begin
      check(fr_addr < data_base + 4 * data_words, 4,
            $sformatf("load from %h outside the data words", fr_addr));
      loaded.push_back(rd_word);
    end
    if (halt_fetched && stores_done == store_count) begin
      done = 1'b1;
    end
  endtask

  task automatic report_test(input int id, input string name);
    if (errors[id] == 0) begin
      $display("Test %0d %s: ok", id, name);
    end else begin
      $display("Test %0d %s: %0d errors", id, name, errors[id]);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  always @(posedge clk) begin
    #1;
    uio_in = uio_next;
    if (run_enable && pause_left == 0 && paused_total + pause_long <= pause_max &&
        ($random(seed) & 31) == 0) begin
      pause_left = pause_long - ($random(seed) & 7);
    end
    paused = (pause_left > 0);
    if (paused) begin
      pause_left--;
      paused_total++;
    end
    ui_in[0] = run_enable && !paused;
    run_low  = ui_in[0] ? 0 : run_low + 1;
  end

  // Frame monitor and memory model, sampled mid cycle
  always @(negedge clk) begin
    if (reset || !run_enable) begin
      check(uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == 8'h00, 1,
            $sformatf("pins %h %h %h while idle", uo_out, uio_out, uio_oe));
    end
    if (!reset && !in_frame) begin
      check(uio_oe == 8'h00, 5, $sformatf("uio_oe %h outside a frame", uio_oe));
      if (uo_out != 8'h00) begin
        check((uo_out & ~8'h01) == (8'h01 << cmd_valid_bit), 5,
              $sformatf("command byte %h", uo_out));
        check(!done, 6, "frame started after the halt instruction");
        in_frame  = 1'b1;
        ph        = 0;
        fr_we     = uo_out[0];
        fr_paused = (run_low > pause_limit);
      end
    end else if (!reset) begin
      ph++;
      if (ph <= word_bytes) begin
        fr_addr[8 * (ph - 1) +: 8]  = uo_out;
        fr_wdata[8 * (ph - 1) +: 8] = uio_out;
        check(uio_oe == (fr_we ? 8'hff : 8'h00), 5,
              $sformatf("uio_oe %h in phase %0d", uio_oe, ph));
        if (ph == word_bytes && !fr_we) begin
          rd_word  = mem[fr_addr[8:2]];
          uio_next = rd_word[7:0];
        end
      end else begin
        check(uio_oe == 8'h00, 5, $sformatf("uio_oe %h in phase %0d", uio_oe, ph));
        uio_next = (ph < phase_last && !fr_we) ? rd_word[8 * (ph - word_bytes) +: 8] : 8'h00;
        if (ph == phase_last) begin
          close_frame();
          in_frame = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the program did not reach halt within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int total;
    seed           = 32'h56a0;
    reset          = 1'b1;
    ui_in          = 8'h00;
    uio_in         = 8'h00;
    uio_next       = 8'h00;
    in_frame       = 1'b0;
    run_enable     = 1'b0;
    branch_pending = 1'b0;
    halt_fetched   = 1'b0;
    done           = 1'b0;
    $readmemh("bench/cpu_handler_stim.txt", stim);
    for (int i = 0; i < 128; i++) begin
      mem[i] = 32'hbad00000 | (i * 4);  // Opcode b halts if fetched
    end
    for (int i = 0; i < prog_words; i++) begin
      mem[i] = stim[i];
    end
    for (int i = 0; i < data_words; i++) begin
      mem[data_base[8:2] + i] = stim[prog_words + i];
    end
    store_count = stim[prog_words + data_words];
    cycle_limit = 4 + idle_cycles + 3 * frame_len + pause_max +
                  2 * (frame_len + 1) * (prog_words + data_words + store_count);

    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    repeat (idle_cycles) @(posedge clk);
    @(negedge clk);
    #1 run_enable = 1'b1;
    report_test(1, "reset and idle");

    wait (done);
    repeat (3 * frame_len) @(posedge clk);  // Bus must stay quiet after halt
    check(stores_done == store_count, 6,
          $sformatf("%0d stores, expected %0d", stores_done, store_count));
    check(loaded.size() == data_words, 4,
          $sformatf("%0d loads, expected %0d", loaded.size(), data_words));
    report_test(2, "fetch order");
    report_test(3, "store content");
    report_test(4, "loads");
    report_test(5, "frame format");
    report_test(6, "halt and pause");

    total = 0;
    for (int i = 1; i <= 6; i++) begin
      total += errors[i];
    end
    $display("Checks %0d, errors %0d, pause cycles %0d", checks, total, paused_total);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* bench/cpu_handler_stim.txt */
// Words 0-15: program at 0x000. Words 16-17: data at 0x100 and 0x104
// Word 18: store count. Then pairs of store address and store data
// addi r1,r0,0x100 / ld r2,0(r1) / addi r3,r2,5 / st r3,8(r1)
32000100 44400000 36800005 56400008
// addi r4,r0,-3 / add r5,r3,r4 / st r5,12(r1) / beqz r0,+8
383FFFFD 0AE00000 5A40000C 60000008
// st r4,16(r1) skipped / ld r6,4(r1) / xor r7,r6,r2 / st r7,16(r1)
58400010 4C400004 2F900000 5E400010
// sub r2,r7,r6 / beqz r2,-8 not taken / st r2,20(r1) / halt
15F00000 60BFFFF8 54400014 70000000
12345678 0F0F00FF
00000004
00000108 1234567D
0000010C 1234567A
00000110 1D3B5687
00000114 0E2C5588

/* compile.f */
hdl/cpu_pkg.sv
hdl/cpu_fetch.sv
hdl/cpu_execute.sv
hdl/bus_arbiter.sv
hdl/pin_sequencer.sv
hdl/cpu_handler_top.sv
bench/cpu_handler_tb.sv
